//--- project.f
design/mci_lite_pkg.sv
design/mci_req_decode.sv
design/mci_reg_bank.sv
design/mci_sram_ctrl.sv
design/mci_resp_queue.sv
design/mci_lite_top.sv
bench/mci_lite_properties.sv
bench/mci_lite_tb.sv

//--- Makefile
# Verilator build and run of the MCI lite testbench
# Every variable can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= mci_lite_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
RUN_ARGS  ?=

.PHONY: run build lint clean

# Build then run, the exit status carries pass or fail
run: build
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -f $(FILELIST)

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- bench/mci_lite_golden.txt
# name write addr wdata user(mcu/clp/soc) exec_lock exp_error exp_rdata flag
# flag: - none, fatal0/fatal1/nmi0 flag value at response, wnmi wait for nmi_intr first
id_read          0 0000 00000000 soc 0 0 4d434c01 -
esize_wr         1 0010 00000010 mcu 0 0 00000000 -
esize_rd         0 0010 00000000 clp 0 0 00000010 -
period_wr_soc    1 0008 00000007 soc 0 1 00000000 -
id_wr            1 0000 12345678 mcu 0 1 00000000 -
bad_idx_rd       0 0024 00000000 mcu 0 1 00000000 -
sram_wr_mcu      1 8080 a5a50001 mcu 0 0 00000000 -
sram_rd_mcu      0 8080 00000000 mcu 0 0 a5a50001 -
sram_wr_clp      1 8084 5a5a0002 clp 0 0 00000000 -
sram_rd_clp      0 8084 00000000 clp 0 0 5a5a0002 -
sram_wr_soc      1 8088 deadbeef soc 0 1 00000000 -
sram_rd_range    0 8400 00000000 mcu 0 1 00000000 -
sram_rd_soc      0 8084 00000000 soc 0 1 00000000 -
exec_wr_clp_open 1 8014 c0de0005 clp 0 0 00000000 fatal0
exec_rd_clp_lock 0 8014 00000000 clp 1 1 00000000 fatal1
exec_wr_mcu_lock 1 8014 0badf00d mcu 1 0 00000000 fatal1
exec_rd_mcu_lock 0 8014 00000000 mcu 1 0 0badf00d fatal1
exec_rd_clp_open 0 8014 00000000 clp 0 0 0badf00d -
wdt_period_wr    1 0008 00000014 mcu 0 0 00000000 -
wdt_period_rd    0 0008 00000000 clp 0 0 00000014 -
wdt_enable       1 0004 00000001 mcu 0 0 00000000 -
wdt_status_rd    0 000c 00000000 clp 0 0 00000001 wnmi
wdt_disable      1 0004 00000000 mcu 0 0 00000000 -
wdt_clear        1 000c 00000001 mcu 0 0 00000000 nmi0
wdt_status_rd2   0 000c 00000000 mcu 0 0 00000000 nmi0

//--- bench/mci_lite_tb.sv
// ******************************
// MCI lite testbench
// Golden file driven requests with
// credit models on both fabrics and
// in-order response checking
// ******************************
`timescale 1ns/10ps
`default_nettype none

module mci_lite_tb;

    localparam string GOLDEN_FILE = "bench/mci_lite_golden.txt";
    localparam logic [mci_lite_pkg::MCI_USER_W-1:0] MCU_USER = 8'h11;
    localparam logic [mci_lite_pkg::MCI_USER_W-1:0] CLP_USER = 8'h22;
    localparam logic [mci_lite_pkg::MCI_USER_W-1:0] SOC_USER = 8'h5a;

    // Numeric columns of one golden line
    typedef struct packed {
        logic                                write;
        mci_lite_pkg::mci_addr_u             addr;
        logic [mci_lite_pkg::MCI_DATA_W-1:0] wdata;
        logic                                lock;
        mci_lite_pkg::mci_resp_t             resp_exp;
    } golden_t;

    logic                                   clk;
    logic                                   rst_n;
    mci_lite_pkg::mci_req_t                 req;
    logic                                   req_credit;
    mci_lite_pkg::mci_resp_t                resp;
    logic                                   resp_credit;
    logic [mci_lite_pkg::MCI_USER_W-1:0]    strap_mcu_user;
    logic [mci_lite_pkg::MCI_USER_W-1:0]    strap_clp_user;
    logic                                   exec_lock;
    logic                                   nmi_intr;
    logic                                   error_fatal;

    golden_t                 lines [$];
    string                   line_name [$];
    string                   line_user [$];
    string                   line_flag [$];
    // Expected responses in request order
    mci_lite_pkg::mci_resp_t exp_resp [$];
    string                   exp_name [$];
    string                   exp_flag [$];
    integer                  seed;
    int                      n_lines;
    int                      req_credits;
    int                      resp_held;
    int                      n_sent;
    int                      n_resp;
    int                      n_credit;
    bit                      pass_printed;
    bit                      fail_printed;

    mci_lite_top uut (
        .clk, .rst_n, .req, .req_credit, .resp, .resp_credit,
        .strap_mcu_user, .strap_clp_user, .exec_lock, .nmi_intr, .error_fatal
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function void announce_failure();
        $display("Checks failed");
        fail_printed = 1'b1;
    endfunction

    task report_failure(input string msg);
        $display("%s", msg);
        announce_failure();
        $fatal(1);
    endtask

    task check_resp(input string name, input mci_lite_pkg::mci_resp_t exp,
                    input mci_lite_pkg::mci_resp_t act);
        if (act !== exp) begin
            report_failure($sformatf("ERROR %s: expected %b/%b/%h actual %b/%b/%h", name,
                                     exp.valid, exp.error, exp.rdata,
                                     act.valid, act.error, act.rdata));
        end
    endtask

    task check_flag(input string name, input string what, input logic exp, input logic act);
        if (act !== exp) begin
            report_failure($sformatf("ERROR %s %s: expected %b actual %b",
                                     name, what, exp, act));
        end
    endtask

    task check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            report_failure($sformatf("ERROR %s: expected %0d actual %0d", name, exp, act));
        end
    endtask

    function logic [mci_lite_pkg::MCI_USER_W-1:0] user_of(input string sel);
        if (sel == "mcu") begin
            return MCU_USER;
        end else if (sel == "clp") begin
            return CLP_USER;
        end
        return SOC_USER;
    endfunction

    task load_golden();
        int                                  fd;
        int                                  cnt;
        string                               text;
        string                               name;
        string                               usel;
        string                               flag;
        logic                                wr;
        logic [mci_lite_pkg::MCI_ADDR_W-1:0] addr_raw;
        logic [mci_lite_pkg::MCI_DATA_W-1:0] wdata;
        logic [mci_lite_pkg::MCI_DATA_W-1:0] rdata;
        logic                                lock;
        logic                                err;
        golden_t                             g;
        fd = $fopen(GOLDEN_FILE, "r");
        if (fd == 0) begin
            report_failure("could not open the golden stimulus file");
        end
        while ($fgets(text, fd) > 0) begin
            // Skip column notes and blank lines
            if (text.len() > 3 && text.getc(0) != "#") begin
                cnt = $sscanf(text, "%s %h %h %h %s %h %h %h %s", name, wr, addr_raw,
                              wdata, usel, lock, err, rdata, flag);
                if (cnt != 9 || !(usel == "mcu" || usel == "clp" || usel == "soc")) begin
                    report_failure({"malformed golden line: ", text});
                end
                g.write          = wr;
                g.addr           = addr_raw;
                g.wdata          = wdata;
                g.lock           = lock;
                g.resp_exp.valid = 1'b1;
                g.resp_exp.error = err;
                g.resp_exp.rdata = rdata;
                lines.push_back(g);
                line_name.push_back(name);
                line_user.push_back(usel);
                line_flag.push_back(flag);
            end
        end
        $fclose(fd);
        if (lines.size() == 0) begin
            report_failure("golden stimulus file holds no requests");
        end
        n_lines = lines.size();
    endtask

    task take_response();
        string name;
        string flag;
        if (exp_resp.size() == 0) begin
            report_failure("response arrived with no request outstanding");
        end else begin
            name = exp_name.pop_front();
            flag = exp_flag.pop_front();
            n_resp++;
            check_resp(name, exp_resp.pop_front(), resp);
            check_flag(name, "req_credit", 1'b1, req_credit);
            if (flag == "fatal0" || flag == "fatal1") begin
                check_flag(name, "error_fatal", flag == "fatal1", error_fatal);
            end else if (flag == "nmi0") begin
                check_flag(name, "nmi_intr", 1'b0, nmi_intr);
            end
        end
    endtask

    // Sample at the falling edge and then drive the next inputs
    task tick();
        @(negedge clk);
        if (req_credit) begin
            n_credit++;
            req_credits++;
        end
        if (resp.valid) begin
            resp_held--;
            take_response();
        end
        if (n_sent - n_resp > mci_lite_pkg::MCI_REQ_CREDITS) begin
            report_failure("more requests in flight than request credits");
        end
        if (req_credits > mci_lite_pkg::MCI_REQ_CREDITS) begin
            report_failure("more request credits returned than were spent");
        end
        req.valid = 1'b0;
        // Downstream has four slots freed at random gaps
        resp_credit = (resp_held < mci_lite_pkg::MCI_REQ_CREDITS) && (($random(seed) & 3) == 0);
        if (resp_credit) begin
            resp_held++;
        end
    endtask

    task drain();
        while (n_resp != n_sent) begin
            tick();
        end
    endtask

    task send_line(input int i);
        int waited;
        // Lock changes only with the pipeline empty
        if (lines[i].lock !== exec_lock || line_flag[i] == "wnmi") begin
            drain();
        end
        exec_lock = lines[i].lock;
        if (line_flag[i] == "wnmi") begin
            waited = 0;
            while (!nmi_intr && waited < 40) begin
                tick();
                waited++;
            end
            check_flag(line_name[i], "nmi_intr", 1'b1, nmi_intr);
        end
        while (req_credits == 0) begin
            tick();
        end
        req.valid = 1'b1;
        req.write = lines[i].write;
        req.addr  = lines[i].addr;
        req.wdata = lines[i].wdata;
        req.user  = user_of(line_user[i]);
        req_credits--;
        n_sent++;
        exp_resp.push_back(lines[i].resp_exp);
        exp_name.push_back(line_name[i]);
        exp_flag.push_back(line_flag[i]);
        tick();
    endtask

    initial begin
        int i;
        seed           = 20;
        rst_n          = 1'b0;
        req            = '0;
        resp_credit    = 1'b0;
        strap_mcu_user = MCU_USER;
        strap_clp_user = CLP_USER;
        exec_lock      = 1'b0;
        req_credits    = mci_lite_pkg::MCI_REQ_CREDITS;
        resp_held      = 0;
        n_sent         = 0;
        n_resp         = 0;
        n_credit       = 0;
        load_golden();
        repeat (16) @(negedge clk);
        check_flag("reset", "resp.valid", 1'b0, resp.valid);
        check_flag("reset", "req_credit", 1'b0, req_credit);
        check_flag("reset", "nmi_intr", 1'b0, nmi_intr);
        check_flag("reset", "error_fatal", 1'b0, error_fatal);
        rst_n = 1'b1;
        for (i = 0; i < n_lines; i++) begin
            send_line(i);
        end
        drain();
        check_count("req_credit pulses", n_resp, n_credit);
        pass_printed = 1'b1;
        $display("All checks passed");
        $finish;
    end

    // Run limit scales with the number of golden lines
    initial begin
        wait (n_lines > 0);
        repeat (n_lines * 40 + 2000) @(posedge clk);
        report_failure("timeout, the run did not finish in time");
    end

    final begin
        if (!pass_printed && !fail_printed) begin
            announce_failure();
        end
    end

endmodule

`default_nettype wire

//--- bench/mci_lite_properties.sv
// ******************************
// MCI lite response queue checks
// Credit return, FIFO occupancy and
// response credit properties
// ******************************
`timescale 1ns/10ps
`default_nettype none

module mci_lite_properties (
    input logic                                         clk,
    input logic                                         rst_n,
    input logic                                         push,
    input logic                                         pop,
    input logic                                         req_credit,
    input logic                                         resp_credit,
    input logic [mci_lite_pkg::MCI_CNT_W-1:0]           fifo_cnt,
    input mci_lite_pkg::mci_resp_t                      resp
);

    // Entries pushed and not yet credited back
    logic [mci_lite_pkg::MCI_CNT_W-1:0]         queued;
    // Response credits granted and not yet used
    logic [mci_lite_pkg::MCI_RESP_CREDIT_W-1:0] granted;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            queued  <= '0;
            granted <= '0;
        end else begin
            queued  <= queued + mci_lite_pkg::MCI_CNT_W'(push)
                              - mci_lite_pkg::MCI_CNT_W'(req_credit);
            granted <= granted + mci_lite_pkg::MCI_RESP_CREDIT_W'(resp_credit)
                               - mci_lite_pkg::MCI_RESP_CREDIT_W'(resp.valid);
        end
    end

    // No request credit without a queued response
    credit_after_push: assert property (@(posedge clk) disable iff (!rst_n)
        req_credit |-> (queued != '0))
        else $error("request credit returned with no response queued");

    // Occupancy bounded by the depth
    fifo_bounded: assert property (@(posedge clk) disable iff (!rst_n)
        fifo_cnt <= mci_lite_pkg::MCI_CNT_W'(mci_lite_pkg::MCI_REQ_CREDITS))
        else $error("response FIFO holds more entries than its depth");

    // Full FIFO only takes a push alongside a pop
    fifo_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        (fifo_cnt == mci_lite_pkg::MCI_CNT_W'(mci_lite_pkg::MCI_REQ_CREDITS)) && push |-> pop)
        else $error("push into a full response FIFO");

    // No response without a downstream credit
    valid_needs_credit: assert property (@(posedge clk) disable iff (!rst_n)
        resp.valid |-> (granted != '0))
        else $error("response presented with zero response credits");

endmodule

bind mci_resp_queue mci_lite_properties i_mci_lite_properties (
    .clk(clk), .rst_n(rst_n), .push(push), .pop(pop), .req_credit(req_credit),
    .resp_credit(resp_credit), .fifo_cnt(fifo_cnt), .resp(resp)
);

`default_nettype wire

//--- design/mci_lite_top.sv
// ******************************
// MCI lite top level
// Decode, register bank, SRAM
// controller and response queue
// ******************************
`timescale 1ns/10ps
`default_nettype none

module mci_lite_top (
    input  logic                                      clk,
    input  logic                                      rst_n,
    // Request fabric
    input  mci_lite_pkg::mci_req_t                    req,
    output logic                                      req_credit,
    // Response fabric
    output mci_lite_pkg::mci_resp_t                   resp,
    input  logic                                      resp_credit,
    // Privileged user straps
    input  logic [mci_lite_pkg::MCI_USER_W-1:0]       strap_mcu_user,
    input  logic [mci_lite_pkg::MCI_USER_W-1:0]       strap_clp_user,
    // Firmware region lock
    input  logic                                      exec_lock,
    output logic                                      nmi_intr,
    output logic                                      error_fatal
);

    mci_lite_pkg::mci_dec_t                       dec;
    mci_lite_pkg::mci_resp_t                      reg_resp;
    mci_lite_pkg::mci_resp_t                      sram_resp;
    logic [mci_lite_pkg::MCI_EXEC_SIZE_W-1:0]     exec_size;

    // Classify and register
    mci_req_decode i_mci_req_decode (
        .clk, .rst_n, .req, .strap_mcu_user, .strap_clp_user, .dec
    );

    // CSRs and watchdog
    mci_reg_bank i_mci_reg_bank (
        .clk, .rst_n, .dec, .resp(reg_resp), .exec_size, .nmi_intr
    );

    // Firmware SRAM
    mci_sram_ctrl i_mci_sram_ctrl (
        .clk, .rst_n, .dec, .exec_size, .exec_lock, .resp(sram_resp), .error_fatal
    );

    mci_resp_queue i_mci_resp_queue (
        .clk, .rst_n, .reg_resp, .sram_resp, .resp_credit, .resp, .req_credit
    );

endmodule

`default_nettype wire

//--- design/mci_resp_queue.sv
// ******************************
// MCI lite response queue
// Merges execute responses into a FIFO,
// pops on response credit and returns
// request credits
// ******************************
`timescale 1ns/10ps
`default_nettype none

module mci_resp_queue (
    input  logic                    clk,
    input  logic                    rst_n,
    input  mci_lite_pkg::mci_resp_t reg_resp,
    input  mci_lite_pkg::mci_resp_t sram_resp,
    input  logic                    resp_credit,
    output mci_lite_pkg::mci_resp_t resp,
    output logic                    req_credit
);

    mci_lite_pkg::mci_resp_t fifo_mem [mci_lite_pkg::MCI_REQ_CREDITS];
    mci_lite_pkg::mci_resp_t push_data;
    logic [mci_lite_pkg::MCI_PTR_W-1:0]         wr_ptr;
    logic [mci_lite_pkg::MCI_PTR_W-1:0]         rd_ptr;
    logic [mci_lite_pkg::MCI_CNT_W-1:0]         fifo_cnt;
    logic [mci_lite_pkg::MCI_RESP_CREDIT_W-1:0] resp_credits;
    logic push;
    logic pop;

    always_comb begin
        // At most one execute side is valid per cycle
        push      = reg_resp.valid || sram_resp.valid;
        push_data = reg_resp.valid ? reg_resp : sram_resp;
        pop       = (fifo_cnt != '0) && (resp_credits != '0);
        resp       = fifo_mem[rd_ptr];
        resp.valid = pop;
        req_credit = pop;
    end

    always_ff @(posedge clk) begin
        if (push) begin
            fifo_mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            fifo_cnt     <= '0;
            resp_credits <= '0;
        end else begin
            // Pointers wrap on the power of two depth
            wr_ptr       <= wr_ptr + mci_lite_pkg::MCI_PTR_W'(push);
            rd_ptr       <= rd_ptr + mci_lite_pkg::MCI_PTR_W'(pop);
            fifo_cnt     <= fifo_cnt + mci_lite_pkg::MCI_CNT_W'(push)
                                     - mci_lite_pkg::MCI_CNT_W'(pop);
            resp_credits <= resp_credits + mci_lite_pkg::MCI_RESP_CREDIT_W'(resp_credit)
                                         - mci_lite_pkg::MCI_RESP_CREDIT_W'(pop);
        end
    end

endmodule

`default_nettype wire

//--- design/mci_sram_ctrl.sv
// ******************************
// MCI lite SRAM controller
// Single port word array with range,
// privilege and execution region checks
// ******************************
`timescale 1ns/10ps
`default_nettype none

module mci_sram_ctrl (
    input  logic                                           clk,
    input  logic                                           rst_n,
    input  mci_lite_pkg::mci_dec_t                         dec,
    input  logic [mci_lite_pkg::MCI_EXEC_SIZE_W-1:0]       exec_size,
    input  logic                                           exec_lock,
    output mci_lite_pkg::mci_resp_t                        resp,
    output logic                                           error_fatal
);

    logic [mci_lite_pkg::MCI_DATA_W-1:0] mem [mci_lite_pkg::MCI_SRAM_WORDS];
    logic [mci_lite_pkg::MCI_SRAM_IDX_W-1:0] word_idx;
    logic sram_hit;
    logic out_of_range;
    logic region_refuse;
    logic acc_err;

    always_comb begin
        sram_hit     = dec.valid && dec.to_sram;
        word_idx     = dec.sram_word[mci_lite_pkg::MCI_SRAM_IDX_W-1:0];
        out_of_range = dec.sram_word >= mci_lite_pkg::MCI_SRAM_WORD_W'(mci_lite_pkg::MCI_SRAM_WORDS);
        // Locked firmware region is MCU only
        region_refuse = exec_lock && (dec.sram_word < {4'b0, exec_size}) &&
                        (dec.priv != mci_lite_pkg::PRIV_MCU);
        acc_err = out_of_range || region_refuse || (dec.priv == mci_lite_pkg::PRIV_SOC);
    end

    // Array write, refused accesses leave it untouched
    always_ff @(posedge clk) begin
        if (sram_hit && dec.write && !acc_err) begin
            mem[word_idx] <= dec.wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            resp        <= '0;
            error_fatal <= 1'b0;
        end else begin
            resp.valid <= sram_hit;
            resp.error <= acc_err;
            resp.rdata <= (dec.write || acc_err) ? '0 : mem[word_idx];
            // Sticky until reset
            if (sram_hit && region_refuse) begin
                error_fatal <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- design/mci_reg_bank.sv
// ******************************
// MCI lite register bank
// ID, watchdog and execution region
// size registers with a single
// watchdog counter driving the NMI
// ******************************
`timescale 1ns/10ps
`default_nettype none

module mci_reg_bank (
    input  logic                                           clk,
    input  logic                                           rst_n,
    input  mci_lite_pkg::mci_dec_t                         dec,
    output mci_lite_pkg::mci_resp_t                        resp,
    output logic [mci_lite_pkg::MCI_EXEC_SIZE_W-1:0]       exec_size,
    output logic                                           nmi_intr
);

    logic                                  wdt_en;
    logic [mci_lite_pkg::MCI_DATA_W-1:0]   wdt_period;
    logic                                  wdt_status;
    logic [mci_lite_pkg::MCI_DATA_W-1:0]   wdt_cnt;
    logic [mci_lite_pkg::MCI_DATA_W-1:0]   rd_data;
    logic                                  reg_hit;
    logic                                  idx_known;
    logic                                  acc_err;
    logic                                  wr_en;
    logic                                  wdt_restart;
    logic                                  wdt_fire;

    always_comb begin
        reg_hit   = dec.valid && !dec.to_sram;
        idx_known = 1'b1;
        rd_data   = '0;
        case (dec.reg_idx)
            mci_lite_pkg::MCI_REG_ID:         rd_data = mci_lite_pkg::MCI_HW_ID;
            mci_lite_pkg::MCI_REG_WDT_EN:     rd_data = {31'b0, wdt_en};
            mci_lite_pkg::MCI_REG_WDT_PERIOD: rd_data = wdt_period;
            mci_lite_pkg::MCI_REG_WDT_STATUS: rd_data = {31'b0, wdt_status};
            mci_lite_pkg::MCI_REG_EXEC_SIZE:  rd_data = {23'b0, exec_size};
            default:                          idx_known = 1'b0;
        endcase
        // Reads open to all classes, writes closed to SOC and to ID
        acc_err = !idx_known || (dec.write && (dec.priv == mci_lite_pkg::PRIV_SOC ||
                                               dec.reg_idx == mci_lite_pkg::MCI_REG_ID));
        wr_en   = reg_hit && dec.write && !acc_err;
        // Enable write restarts the count
        wdt_restart = wr_en && (dec.reg_idx == mci_lite_pkg::MCI_REG_WDT_EN);
        wdt_fire    = wdt_en && !wdt_restart && (wdt_cnt == wdt_period);
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            resp       <= '0;
            wdt_en     <= 1'b0;
            wdt_period <= '0;
            wdt_status <= 1'b0;
            wdt_cnt    <= '0;
            exec_size  <= '0;
        end else begin
            resp.valid <= reg_hit;
            resp.error <= acc_err;
            resp.rdata <= (dec.write || acc_err) ? '0 : rd_data;
            if (wdt_restart) begin
                wdt_en  <= dec.wdata[0];
                wdt_cnt <= '0;
            end else if (wdt_fire) begin
                wdt_cnt <= '0;
            end else if (wdt_en) begin
                wdt_cnt <= wdt_cnt + 1;
            end
            // Write one to clear beats a timeout in the same cycle
            if (wr_en && dec.reg_idx == mci_lite_pkg::MCI_REG_WDT_STATUS && dec.wdata[0]) begin
                wdt_status <= 1'b0;
            end else if (wdt_fire) begin
                wdt_status <= 1'b1;
            end
            if (wr_en && dec.reg_idx == mci_lite_pkg::MCI_REG_WDT_PERIOD) begin
                wdt_period <= dec.wdata;
            end
            if (wr_en && dec.reg_idx == mci_lite_pkg::MCI_REG_EXEC_SIZE) begin
                exec_size <= dec.wdata[mci_lite_pkg::MCI_EXEC_SIZE_W-1:0];
            end
        end
    end

    // NMI tracks the sticky timeout flag
    assign nmi_intr = wdt_status;

endmodule

`default_nettype wire

//--- design/mci_req_decode.sv
// ******************************
// MCI lite request decode
// Registers each request, maps the user
// field to a privilege class and splits
// the address into register or SRAM index
// ******************************
`timescale 1ns/10ps
`default_nettype none

module mci_req_decode (
    input  logic                                      clk,
    input  logic                                      rst_n,
    input  mci_lite_pkg::mci_req_t                    req,
    input  logic [mci_lite_pkg::MCI_USER_W-1:0]       strap_mcu_user,
    input  logic [mci_lite_pkg::MCI_USER_W-1:0]       strap_clp_user,
    output mci_lite_pkg::mci_dec_t                    dec
);

    mci_lite_pkg::mci_priv_e priv_nxt;
    logic                    to_sram_nxt;

    always_comb begin
        // MCU strap checked first, matches win over SOC default
        if (req.user == strap_mcu_user) begin
            priv_nxt = mci_lite_pkg::PRIV_MCU;
        end else if (req.user == strap_clp_user) begin
            priv_nxt = mci_lite_pkg::PRIV_CLP;
        end else begin
            priv_nxt = mci_lite_pkg::PRIV_SOC;
        end
        // Region bit sits at the top of both views
        to_sram_nxt = req.addr.regs.region;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dec <= '0;
        end else begin
            dec.valid   <= req.valid;
            dec.write   <= req.write;
            dec.to_sram <= to_sram_nxt;
            dec.priv    <= priv_nxt;
            dec.wdata   <= req.wdata;
            // Only the selected view carries an index
            if (to_sram_nxt) begin
                dec.reg_idx   <= '0;
                dec.sram_word <= req.addr.sram.word;
            end else begin
                dec.reg_idx   <= req.addr.regs.idx;
                dec.sram_word <= '0;
            end
        end
    end

endmodule

`default_nettype wire

//--- design/mci_lite_pkg.sv
// ******************************
// MCI lite shared definitions
// Sizes, register map, request and
// response types for the MCI lite block
// ******************************
`default_nettype none

package mci_lite_pkg;

    // Fabric widths
    localparam int MCI_ADDR_W = 16;
    localparam int MCI_DATA_W = 32;
    localparam int MCI_USER_W = 8;

    // Credits and queue depth
    localparam int MCI_REQ_CREDITS   = 4;
    localparam int MCI_PTR_W         = $clog2(MCI_REQ_CREDITS);
    localparam int MCI_CNT_W         = MCI_PTR_W + 1;
    localparam int MCI_RESP_CREDIT_W = 4;

    // SRAM geometry
    localparam int MCI_SRAM_WORDS  = 256;
    localparam int MCI_SRAM_IDX_W  = $clog2(MCI_SRAM_WORDS);
    localparam int MCI_SRAM_WORD_W = 13;
    localparam int MCI_EXEC_SIZE_W = 9;

    // Register map
    localparam int               MCI_REG_IDX_W      = 6;
    localparam logic [MCI_DATA_W-1:0] MCI_HW_ID     = 32'h4d43_4c01;
    localparam logic [5:0]       MCI_REG_ID         = 6'd0;
    localparam logic [5:0]       MCI_REG_WDT_EN     = 6'd1;
    localparam logic [5:0]       MCI_REG_WDT_PERIOD = 6'd2;
    localparam logic [5:0]       MCI_REG_WDT_STATUS = 6'd3;
    localparam logic [5:0]       MCI_REG_EXEC_SIZE  = 6'd4;

    // Register view of an address, region bit low
    typedef struct packed {
        logic                     region;
        logic [6:0]               rsvd;
        logic [MCI_REG_IDX_W-1:0] idx;
        logic [1:0]               byte_sel;
    } mci_reg_addr_t;

    // SRAM view of an address, region bit high
    typedef struct packed {
        logic                       region;
        logic [MCI_SRAM_WORD_W-1:0] word;
        logic [1:0]                 byte_sel;
    } mci_sram_addr_t;

    typedef union packed {
        mci_reg_addr_t  regs;
        mci_sram_addr_t sram;
    } mci_addr_u;

    typedef struct packed {
        logic                  valid;
        logic                  write;
        mci_addr_u             addr;
        logic [MCI_DATA_W-1:0] wdata;
        logic [MCI_USER_W-1:0] user;
    } mci_req_t;

    typedef enum logic [1:0] {
        PRIV_MCU = 2'd0,
        PRIV_CLP = 2'd1,
        PRIV_SOC = 2'd2
    } mci_priv_e;

    typedef struct packed {
        logic                       valid;
        logic                       write;
        logic                       to_sram;
        mci_priv_e                  priv;
        logic [MCI_REG_IDX_W-1:0]   reg_idx;
        logic [MCI_SRAM_WORD_W-1:0] sram_word;
        logic [MCI_DATA_W-1:0]      wdata;
    } mci_dec_t;

    typedef struct packed {
        logic                  valid;
        logic                  error;
        logic [MCI_DATA_W-1:0] rdata;
    } mci_resp_t;

endpackage

`default_nettype wire
